// File: hw/rename_pkg.sv
// shared widths, types and constants for the rename and retire core
// imported by every block that needs a data word or an architectural register number
`default_nettype none

package rename_pkg;

	localparam int XLEN             = 64;   // data word width
	localparam int ARCH_REGS        = 32;   // architectural register count
	localparam int NUM_RESULT_PORTS = 2;    // result ports competing for the cdb

	typedef logic [XLEN-1:0]               word_t;  // one data value
	typedef logic [$clog2(ARCH_REGS)-1:0]  arn_t;   // architectural register number

	// r31 is hardwired to zero, never renamed
	localparam arn_t ZERO_REG = 5'd31;

endpackage

`default_nettype wire

// File: hw/rename_table.sv
// speculative map from architectural to physical register numbers
// one source lookup and one destination rewrite per dispatch
`timescale 1ns/1ps
`default_nettype none

module rename_table #(
	parameter int PRF_SIZE = 40
) (
	input  wire logic                           clock,
	input  wire logic                           rst_n,
	input  wire rename_pkg::arn_t               dispatch_dest_arn,
	input  wire rename_pkg::arn_t               dispatch_src_arn,
	input  wire logic                           dispatch_fire,
	input  wire logic [$clog2(PRF_SIZE)-1:0]    alloc_prn,      // new register from free list
	output logic                                rename_req,     // dest needs a fresh register
	output logic [$clog2(PRF_SIZE)-1:0]         src_prn,
	output logic [$clog2(PRF_SIZE)-1:0]         old_prn         // mapping being replaced
);

	import rename_pkg::*;

	localparam int PRN_W = $clog2(PRF_SIZE);

	logic [PRN_W-1:0] map_q [ARCH_REGS];    // current speculative mapping

	// zero register writes are dropped, so no allocation for them
	assign rename_req = (dispatch_dest_arn != ZERO_REG);

	// lookups see the table before this cycle's update
	assign src_prn = map_q[dispatch_src_arn];   // src == dest gets the older producer
	assign old_prn = map_q[dispatch_dest_arn];  // handed to the rob, freed at retire

	////////////////////////////////////////////////////////////////////////////
	// table update
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int r = 0; r < ARCH_REGS; r++) begin
				map_q[r] <= PRN_W'(r);          // identity map out of reset
			end
		end else if (dispatch_fire && rename_req) begin
			map_q[dispatch_dest_arn] <= alloc_prn;
		end
	end

endmodule

`default_nettype wire

// File: hw/free_list.sv
// pool of unallocated physical registers, one bit each
// offers the lowest free index, takes back registers released at retire
`timescale 1ns/1ps
`default_nettype none

module free_list #(
	parameter int PRF_SIZE = 40
) (
	input  wire logic                           clock,
	input  wire logic                           rst_n,
	input  wire logic                           alloc_en,   // renamed dispatch this cycle
	input  wire logic                           free_en,    // retire of a renamed entry
	input  wire logic [$clog2(PRF_SIZE)-1:0]    free_prn,
	output logic [$clog2(PRF_SIZE)-1:0]         alloc_prn,
	output logic                                free_empty
);

	import rename_pkg::*;

	localparam int PRN_W = $clog2(PRF_SIZE);

	logic [PRF_SIZE-1:0] free_q;    // 1 = register available

	assign free_empty = ~|free_q;

	// lowest-index pick, scanning downward so the last hit wins
	always_comb begin
		alloc_prn = '0;
		for (int i = PRF_SIZE - 1; i >= 0; i--) begin
			if (free_q[i]) begin
				alloc_prn = PRN_W'(i);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// allocate and release
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < PRF_SIZE; i++) begin
				free_q[i] <= (i >= ARCH_REGS);  // low registers hold the arch state
			end
		end else begin
			if (alloc_en) begin
				free_q[alloc_prn] <= 1'b0;
			end
			// a register being freed is never the one being allocated
			if (free_en) begin
				free_q[free_prn] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/phys_regfile.sv
// physical register values and ready bits
// source and retire read ports are combinational, the cdb is the only writer
`timescale 1ns/1ps
`default_nettype none

module phys_regfile #(
	parameter int PRF_SIZE = 40
) (
	input  wire logic                           clock,
	input  wire logic                           rst_n,
	input  wire logic [$clog2(PRF_SIZE)-1:0]    src_prn,
	input  wire logic                           alloc_en,
	input  wire logic [$clog2(PRF_SIZE)-1:0]    alloc_prn,
	input  wire logic                           cdb_valid,
	input  wire logic [$clog2(PRF_SIZE)-1:0]    cdb_prn,
	input  wire rename_pkg::word_t              cdb_value,
	input  wire logic [$clog2(PRF_SIZE)-1:0]    commit_prn,
	output logic                                src_ready,
	output rename_pkg::word_t                   src_value,
	output rename_pkg::word_t                   commit_value
);

	import rename_pkg::*;

	localparam int PRN_W = $clog2(PRF_SIZE);
	// the zero register keeps its identity mapping forever
	localparam logic [PRN_W-1:0] ZERO_PRN = PRN_W'(ZERO_REG);

	word_t               value_q [PRF_SIZE];
	logic [PRF_SIZE-1:0] ready_q;

	// no bypass, a cdb write shows up one cycle later
	assign src_ready    = ready_q[src_prn];
	assign src_value    = value_q[src_prn];
	assign commit_value = value_q[commit_prn];  // zero-dest entries point at ZERO_PRN

	////////////////////////////////////////////////////////////////////////////
	// write port and readiness
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < PRF_SIZE; i++) begin
				value_q[i] <= '0;
			end
			ready_q <= '1;
		end else begin
			if (alloc_en) begin
				ready_q[alloc_prn] <= 1'b0;         // producer now in flight
			end
			if (cdb_valid && cdb_prn != ZERO_PRN) begin  // results for r31 are dropped
				value_q[cdb_prn] <= cdb_value;
				ready_q[cdb_prn] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/cdb_arbiter.sv
// fixed-priority pick of one result port per cycle onto the common data bus
// the grant pulse tells the winning port its result was taken
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter #(
	parameter int ROB_SIZE = 16
) (
	input  wire logic [rename_pkg::NUM_RESULT_PORTS-1:0]    result_valid,
	input  wire logic [rename_pkg::NUM_RESULT_PORTS-1:0][$clog2(ROB_SIZE)-1:0] result_rob_idx,
	input  wire rename_pkg::word_t [rename_pkg::NUM_RESULT_PORTS-1:0] result_value,
	output logic [rename_pkg::NUM_RESULT_PORTS-1:0]         result_grant,
	output logic                                            cdb_valid,
	output logic [$clog2(ROB_SIZE)-1:0]                     cdb_rob_idx,
	output rename_pkg::word_t                               cdb_value
);

	import rename_pkg::*;

	// port 0 wins, an ungranted port keeps its result up
	always_comb begin
		result_grant = '0;
		cdb_rob_idx  = '0;
		cdb_value    = '0;
		for (int i = NUM_RESULT_PORTS - 1; i >= 0; i--) begin  // lowest valid port last
			if (result_valid[i]) begin
				result_grant = '0;
				result_grant[i] = 1'b1;
				cdb_rob_idx  = result_rob_idx[i];
				cdb_value    = result_value[i];
			end
		end
	end

	assign cdb_valid = |result_valid;   // something always wins when any port asks

endmodule

`default_nettype wire

// File: hw/reorder_buffer.sv
// circular in-order buffer between dispatch and retire
// accepts dispatches, marks entries done from the cdb and retires the head
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
	parameter int PRF_SIZE = 40,
	parameter int ROB_SIZE = 16
) (
	input  wire logic                           clock,
	input  wire logic                           rst_n,
	input  wire logic                           dispatch_valid,
	input  wire rename_pkg::arn_t               dispatch_dest_arn,
	input  wire logic                           rename_req,
	input  wire logic                           free_empty,
	input  wire logic [$clog2(PRF_SIZE)-1:0]    alloc_prn,
	input  wire logic [$clog2(PRF_SIZE)-1:0]    old_prn,
	input  wire logic                           cdb_valid,
	input  wire logic [$clog2(ROB_SIZE)-1:0]    cdb_rob_idx,
	output logic                                dispatch_ready,
	output logic                                dispatch_fire,
	output logic [$clog2(ROB_SIZE)-1:0]         dispatch_rob_idx,
	output logic [$clog2(PRF_SIZE)-1:0]         cdb_prn,        // target of the cdb write
	output logic                                commit_valid,
	output rename_pkg::arn_t                    commit_arn,
	output logic                                commit_wr_en,
	output logic [$clog2(PRF_SIZE)-1:0]         commit_prn,
	output logic                                free_en,
	output logic [$clog2(PRF_SIZE)-1:0]         free_prn
);

	import rename_pkg::*;

	localparam int PRN_W = $clog2(PRF_SIZE);
	localparam int ROB_W = $clog2(ROB_SIZE);

	// per-entry state
	logic [ROB_SIZE-1:0] done_q;                // result has been on the cdb
	logic [ROB_SIZE-1:0] renamed_q;             // entry holds a fresh register
	arn_t                dest_q    [ROB_SIZE];
	logic [PRN_W-1:0]    new_prn_q [ROB_SIZE];
	logic [PRN_W-1:0]    old_prn_q [ROB_SIZE];

	logic [ROB_W-1:0] head_q, tail_q;
	logic [ROB_W:0]   count_q;                  // one extra bit to tell full from empty
	logic             full;

	// pointer step with explicit wrap, depth need not be a power of two
	function automatic logic [ROB_W-1:0] ptr_next(input logic [ROB_W-1:0] ptr);
		return (ptr == ROB_W'(ROB_SIZE - 1)) ? '0 : ptr + 1'b1;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// dispatch side
	////////////////////////////////////////////////////////////////////////////
	assign full             = (count_q == (ROB_W + 1)'(ROB_SIZE));
	assign dispatch_ready   = !full && (!rename_req || !free_empty);   // zero dest needs no prn
	assign dispatch_fire    = dispatch_valid && dispatch_ready;
	assign dispatch_rob_idx = tail_q;

	assign cdb_prn = new_prn_q[cdb_rob_idx];    // prf write goes where the entry renamed to

	////////////////////////////////////////////////////////////////////////////
	// retire side
	////////////////////////////////////////////////////////////////////////////
	assign commit_valid = (count_q != '0) && done_q[head_q];
	assign commit_arn   = dest_q[head_q];
	assign commit_wr_en = renamed_q[head_q];
	assign commit_prn   = new_prn_q[head_q];
	assign free_en      = commit_valid && renamed_q[head_q];  // old mapping is now dead
	assign free_prn     = old_prn_q[head_q];

	// control state
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
			done_q  <= '0;
		end else begin
			if (cdb_valid) begin
				done_q[cdb_rob_idx] <= 1'b1;
			end
			if (dispatch_fire) begin
				done_q[tail_q] <= 1'b0;
				tail_q         <= ptr_next(tail_q);
			end
			if (commit_valid) begin
				head_q <= ptr_next(head_q);     // one retire per cycle at most
			end
			case ({dispatch_fire, commit_valid})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;   // both or neither
			endcase
		end
	end

	// entry payload, written at the tail only
	always_ff @(posedge clock) begin
		if (dispatch_fire) begin
			dest_q[tail_q]    <= dispatch_dest_arn;
			renamed_q[tail_q] <= rename_req;
			new_prn_q[tail_q] <= rename_req ? alloc_prn : PRN_W'(ZERO_REG);
			old_prn_q[tail_q] <= old_prn;
		end
	end

endmodule

`default_nettype wire

// File: hw/rename_core.sv
// top level of the single-issue rename and retire core
// dispatch, result and commit ports go straight out, the testbench plays the fus
`timescale 1ns/1ps
`default_nettype none

module rename_core #(
	parameter int PRF_SIZE = 40,
	parameter int ROB_SIZE = 16
) (
	input  wire logic                                       clock,
	input  wire logic                                       rst_n,
	// dispatch
	input  wire logic                                       dispatch_valid,
	input  wire rename_pkg::arn_t                           dispatch_dest_arn,
	input  wire rename_pkg::arn_t                           dispatch_src_arn,
	output logic                                            dispatch_ready,
	output logic [$clog2(ROB_SIZE)-1:0]                     dispatch_rob_idx,
	output logic                                            src_ready,
	output rename_pkg::word_t                               src_value,
	// completion
	input  wire logic [rename_pkg::NUM_RESULT_PORTS-1:0]    result_valid,
	input  wire logic [rename_pkg::NUM_RESULT_PORTS-1:0][$clog2(ROB_SIZE)-1:0] result_rob_idx,
	input  wire rename_pkg::word_t [rename_pkg::NUM_RESULT_PORTS-1:0] result_value,
	output logic [rename_pkg::NUM_RESULT_PORTS-1:0]         result_grant,
	// retire
	output logic                                            commit_valid,
	output rename_pkg::arn_t                                commit_arn,
	output logic                                            commit_wr_en,
	output rename_pkg::word_t                               commit_value
);

	import rename_pkg::*;

	localparam int PRN_W = $clog2(PRF_SIZE);
	localparam int ROB_W = $clog2(ROB_SIZE);

	logic             rename_req, dispatch_fire, alloc_en, free_empty;
	logic [PRN_W-1:0] alloc_prn, src_prn, old_prn;
	logic             free_en;
	logic [PRN_W-1:0] free_prn, commit_prn, cdb_prn;
	logic             cdb_valid;
	logic [ROB_W-1:0] cdb_rob_idx;
	word_t            cdb_value;

	assign alloc_en = dispatch_fire && rename_req;  // zero dest takes nothing from the pool

	//////////////////////////////////////////////////////////////////////////
	// rename
	//////////////////////////////////////////////////////////////////////////
	rename_table #(.PRF_SIZE(PRF_SIZE)) u_rename_table (
		.clock, .rst_n, .dispatch_dest_arn, .dispatch_src_arn, .dispatch_fire,
		.alloc_prn, .rename_req, .src_prn, .old_prn
	);

	free_list #(.PRF_SIZE(PRF_SIZE)) u_free_list (
		.clock, .rst_n, .alloc_en, .free_en, .free_prn, .alloc_prn, .free_empty
	);

	phys_regfile #(.PRF_SIZE(PRF_SIZE)) u_phys_regfile (
		.clock, .rst_n, .src_prn, .alloc_en, .alloc_prn, .cdb_valid, .cdb_prn,
		.cdb_value, .commit_prn, .src_ready, .src_value, .commit_value
	);

	//////////////////////////////////////////////////////////////////////////
	// completion and retire
	//////////////////////////////////////////////////////////////////////////
	cdb_arbiter #(.ROB_SIZE(ROB_SIZE)) u_cdb_arbiter (
		.result_valid, .result_rob_idx, .result_value,
		.result_grant, .cdb_valid, .cdb_rob_idx, .cdb_value
	);

	reorder_buffer #(.PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE)) u_reorder_buffer (
		.clock, .rst_n, .dispatch_valid, .dispatch_dest_arn, .rename_req, .free_empty,
		.alloc_prn, .old_prn, .cdb_valid, .cdb_rob_idx,
		.dispatch_ready, .dispatch_fire, .dispatch_rob_idx, .cdb_prn,
		.commit_valid, .commit_arn, .commit_wr_en, .commit_prn, .free_en, .free_prn
	);

endmodule

`default_nettype wire

// File: tb/rename_core_checker.sv
// concurrent assertions on the core's grant and retire ports, bound into rename_core
`timescale 1ns/1ps
`default_nettype none

module rename_core_checker (
	input  wire logic                                       clock,
	input  wire logic                                       rst_n,
	input  wire logic [rename_pkg::NUM_RESULT_PORTS-1:0]    result_grant,
	input  wire logic                                       commit_valid,
	input  wire logic                                       commit_wr_en,
	input  wire rename_pkg::word_t                          commit_value
);

	import rename_pkg::*;

	logic seen_grant;       // any grant since reset
	int   assert_fails = 0;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			seen_grant <= 1'b0;
		end else if (|result_grant) begin
			seen_grant <= 1'b1;
		end
	end

	grant_onehot: assert property (@(posedge clock) disable iff (!rst_n)
		$onehot0(result_grant))
		else begin
			$error("more than one result port granted");
			assert_fails++;
		end

	// zero-dest retire reads the hardwired zero register
	zero_commit_value: assert property (@(posedge clock) disable iff (!rst_n)
		commit_valid && !commit_wr_en |-> commit_value == '0)
		else begin
			$error("commit_value not zero with commit_wr_en low");
			assert_fails++;
		end

	no_early_commit: assert property (@(posedge clock) disable iff (!rst_n)
		!seen_grant |-> !commit_valid)
		else begin
			$error("commit_valid raised before any result was granted");
			assert_fails++;
		end

endmodule

`default_nettype wire

// File: tb/rename_scoreboard.sv
// compares the core's outputs with the reference model's predictions at each rising edge
// one ERROR line per mismatch, the running count goes back to the testbench
`timescale 1ns/1ps
`default_nettype none

module rename_scoreboard #(
	parameter int ROB_SIZE = 16
) (
	input  wire logic                                       clock,
	input  wire logic                                       rst_n,
	input  wire logic                                       dispatch_valid,
	input  wire logic                                       dispatch_ready,
	input  wire logic                                       exp_dispatch_ready,
	input  wire logic [$clog2(ROB_SIZE)-1:0]                dispatch_rob_idx,
	input  wire logic [$clog2(ROB_SIZE)-1:0]                exp_rob_idx,
	input  wire logic                                       src_ready,
	input  wire logic                                       exp_src_ready,
	input  wire rename_pkg::word_t                          src_value,
	input  wire rename_pkg::word_t                          exp_src_value,
	input  wire logic [rename_pkg::NUM_RESULT_PORTS-1:0]    result_grant,
	input  wire logic [rename_pkg::NUM_RESULT_PORTS-1:0]    exp_grant,
	input  wire logic                                       commit_valid,
	input  wire logic                                       exp_commit_valid,
	input  wire rename_pkg::arn_t                           commit_arn,
	input  wire rename_pkg::arn_t                           exp_commit_arn,
	input  wire logic                                       commit_wr_en,
	input  wire logic                                       exp_commit_wr_en,
	input  wire rename_pkg::word_t                          commit_value,
	input  wire rename_pkg::word_t                          exp_commit_value,
	output int                                              error_count
);

	import rename_pkg::*;

	int errors = 0;

	assign error_count = errors;

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	always @(posedge clock) begin
		if (rst_n) begin
			compare("dispatch_ready", dispatch_ready, exp_dispatch_ready);
			compare("result_grant", result_grant, exp_grant);
			compare("commit_valid", commit_valid, exp_commit_valid);
			if (dispatch_valid) begin
				compare("src_ready", src_ready, exp_src_ready);
				if (exp_src_ready) begin
					compare("src_value", src_value, exp_src_value);  // stale until ready
				end
				if (exp_dispatch_ready) begin
					compare("dispatch_rob_idx", dispatch_rob_idx, exp_rob_idx);
				end
			end
			if (exp_commit_valid) begin         // retire order and payload
				compare("commit_arn", commit_arn, exp_commit_arn);
				compare("commit_wr_en", commit_wr_en, exp_commit_wr_en);
				compare("commit_value", commit_value, exp_commit_value);
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/rename_core_tb.sv
// testbench for the rename and retire core, plays dispatch and the two execution units
// a reference model predicts every cycle's outputs, rename_scoreboard compares them
`timescale 1ns/1ps
`default_nettype none

module rename_core_tb;

	import rename_pkg::*;

	localparam int PRF_SIZE = 40;
	localparam int ROB_SIZE = 16;
	localparam int ROB_W    = $clog2(ROB_SIZE);
	localparam int LIMIT    = 200;      // cycles any single wait may take

	logic clock = 1'b0;
	logic rst_n;
	logic dispatch_valid;
	arn_t dispatch_dest_arn;
	arn_t dispatch_src_arn;
	logic [NUM_RESULT_PORTS-1:0]            result_valid;
	logic [NUM_RESULT_PORTS-1:0][ROB_W-1:0] result_rob_idx;
	word_t [NUM_RESULT_PORTS-1:0]           result_value;

	// dut outputs
	logic                        dispatch_ready, src_ready, commit_valid, commit_wr_en;
	logic [ROB_W-1:0]            dispatch_rob_idx;
	word_t                       src_value, commit_value;
	logic [NUM_RESULT_PORTS-1:0] result_grant;
	arn_t                        commit_arn;

	// predictions handed to the scoreboard
	logic                        exp_dispatch_ready, exp_src_ready;
	logic                        exp_commit_valid, exp_commit_wr_en;
	logic [ROB_W-1:0]            exp_rob_idx;
	word_t                       exp_src_value, exp_commit_value;
	logic [NUM_RESULT_PORTS-1:0] exp_grant;
	arn_t                        exp_commit_arn;
	int                          sb_errors;

	////////////////////////////////////////////////////////////////////////////
	// reference model state
	////////////////////////////////////////////////////////////////////////////
	int    map_m    [ARCH_REGS];    // arch -> phys
	bit    ready_m  [PRF_SIZE];
	word_t value_m  [PRF_SIZE];
	bit    free_m   [PRF_SIZE];
	arn_t  rob_dest [ROB_SIZE];
	bit    rob_ren  [ROB_SIZE];
	bit    rob_done [ROB_SIZE];
	int    rob_new  [ROB_SIZE];
	int    rob_old  [ROB_SIZE];
	word_t rob_val  [ROB_SIZE];     // value the entry completed with
	int    head_m, tail_m, count_m;

	// run bookkeeping
	int                          tb_errors = 0;
	int                          failed_tests = 0;
	int                          err_base = 0;
	int                          commits_seen;
	logic [NUM_RESULT_PORTS-1:0] granted;   // grant seen at the last edge
	logic                        fired;     // dispatch taken at the last edge
	logic [ROB_W-1:0]            rob_ids [$];

	rename_core #(.PRF_SIZE(PRF_SIZE), .ROB_SIZE(ROB_SIZE)) dut (.*);

	rename_scoreboard #(.ROB_SIZE(ROB_SIZE)) u_scoreboard (.*, .error_count(sb_errors));

	bind rename_core rename_core_checker u_checker (.*);

	always #5 clock = ~clock;

	function automatic void model_reset();
		for (int r = 0; r < ARCH_REGS; r++) begin
			map_m[r] = r;                   // identity map
		end
		for (int p = 0; p < PRF_SIZE; p++) begin
			ready_m[p] = 1'b1;
			value_m[p] = '0;
			free_m[p]  = (p >= ARCH_REGS);
		end
		for (int e = 0; e < ROB_SIZE; e++) begin
			rob_done[e] = 1'b0;
		end
		head_m  = 0;
		tail_m  = 0;
		count_m = 0;
	endfunction

	// expected outputs for the inputs driven this cycle
	function automatic void predict();
		bit any_free;
		int src_p;
		any_free = 1'b0;
		for (int p = 0; p < PRF_SIZE; p++) begin
			any_free |= free_m[p];
		end
		exp_dispatch_ready = (count_m < ROB_SIZE) && (dispatch_dest_arn == ZERO_REG || any_free);
		exp_rob_idx        = ROB_W'(tail_m);
		src_p              = map_m[dispatch_src_arn];   // mapping before this cycle's rename
		exp_src_ready      = ready_m[src_p];
		exp_src_value      = value_m[src_p];
		exp_grant          = result_valid[0] ? 2'b01 : (result_valid[1] ? 2'b10 : 2'b00);
		exp_commit_valid   = (count_m > 0) && rob_done[head_m];
		exp_commit_arn     = rob_dest[head_m];
		exp_commit_wr_en   = rob_ren[head_m];
		exp_commit_value   = rob_ren[head_m] ? rob_val[head_m] : '0;
	endfunction

	// model state after the clock edge, built from its own predictions
	function automatic void advance();
		int port;
		int idx;
		int p;
		port = exp_grant[0] ? 0 : 1;
		if (|exp_grant) begin
			idx           = result_rob_idx[port];
			rob_done[idx] = 1'b1;
			rob_val[idx]  = result_value[port];
			if (rob_ren[idx]) begin
				value_m[rob_new[idx]] = result_value[port];
				ready_m[rob_new[idx]] = 1'b1;
			end
		end
		if (dispatch_valid && exp_dispatch_ready) begin
			rob_dest[tail_m] = dispatch_dest_arn;
			rob_ren[tail_m]  = (dispatch_dest_arn != ZERO_REG);
			rob_done[tail_m] = 1'b0;
			if (rob_ren[tail_m]) begin
				p = 0;
				while (!free_m[p]) begin    // lowest free register
					p++;
				end
				free_m[p]                = 1'b0;
				ready_m[p]               = 1'b0;
				rob_new[tail_m]          = p;
				rob_old[tail_m]          = map_m[dispatch_dest_arn];
				map_m[dispatch_dest_arn] = p;
			end
			tail_m = (tail_m + 1) % ROB_SIZE;
			count_m++;
		end
		if (exp_commit_valid) begin
			if (rob_ren[head_m]) begin
				free_m[rob_old[head_m]] = 1'b1; // previous mapping is dead now
			end
			head_m = (head_m + 1) % ROB_SIZE;
			count_m--;
		end
	endfunction

	function automatic int all_errors();
		return sb_errors + tb_errors + dut.u_checker.assert_fails;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus tasks, called and returning on the falling edge
	////////////////////////////////////////////////////////////////////////////
	task automatic tick();
		predict();
		@(posedge clock);
		granted = result_grant;
		fired   = dispatch_valid && dispatch_ready;
		if (commit_valid) begin
			commits_seen++;
		end
		advance();
		@(negedge clock);
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s within %0d cycles", what, LIMIT);
		tb_errors++;
	endtask

	task automatic apply_reset();
		rst_n             = 1'b0;
		dispatch_valid    = 1'b0;
		dispatch_dest_arn = '0;
		dispatch_src_arn  = '0;
		result_valid      = '0;
		result_rob_idx    = '0;
		result_value      = '0;
		granted           = '0;
		fired             = 1'b0;
		repeat (3) @(negedge clock);
		rst_n = 1'b1;
		model_reset();
		commits_seen = 0;
		rob_ids.delete();
	endtask

	// hold one dispatch until the core takes it
	task automatic dispatch_one(input arn_t dest, input arn_t src);
		int n;
		dispatch_valid    = 1'b1;
		dispatch_dest_arn = dest;
		dispatch_src_arn  = src;
		fired             = 1'b0;
		n                 = 0;
		while (!fired && n < LIMIT) begin
			tick();
			n++;
		end
		dispatch_valid = 1'b0;
		if (fired) begin
			rob_ids.push_back(exp_rob_idx);     // tag of the accepting cycle
		end else begin
			report_timeout("dispatch was not accepted");
		end
	endtask

	// dispatch request held a few cycles where it is expected to stall
	task automatic probe(input arn_t dest, input int cycles);
		dispatch_valid    = 1'b1;
		dispatch_dest_arn = dest;
		dispatch_src_arn  = ZERO_REG;
		repeat (cycles) tick();
		dispatch_valid = 1'b0;
	endtask

	// each port keeps its result up until granted
	task automatic drain_results();
		int n;
		n = 0;
		while (|result_valid && n < LIMIT) begin
			tick();
			result_valid = result_valid & ~granted;
			n++;
		end
		if (|result_valid) begin
			report_timeout("a result port was not granted");
			result_valid = '0;
		end
	endtask

	task automatic complete(input int port, input logic [ROB_W-1:0] idx, input word_t value);
		result_valid[port]   = 1'b1;
		result_rob_idx[port] = idx;
		result_value[port]   = value;
		drain_results();
	endtask

	task automatic wait_commits(input int target);
		int n;
		n = 0;
		while (commits_seen < target && n < LIMIT) begin
			tick();
			n++;
		end
		if (commits_seen < target) begin
			report_timeout("expected retirements did not happen");
		end
	endtask

	task automatic finish_test(input int num, input string name);
		int errs;
		errs = all_errors() - err_base;
		if (errs == 0) begin
			$display("test %0d %s: PASS", num, name);
		end else begin
			$display("test %0d %s: FAIL with %0d errors", num, name, errs);
			failed_tests++;
		end
		err_base = all_errors();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////
	initial begin
		arn_t             d;
		int               j;
		logic [ROB_W-1:0] t;
		void'($urandom(32'h6260_30cd));

		// 1: random dests, two of them r31 so the eight free registers suffice
		apply_reset();
		for (int i = 0; i < 10; i++) begin
			d = (i % 5 == 4) ? ZERO_REG : arn_t'($urandom % 31);
			dispatch_one(d, arn_t'($urandom % 32));
		end
		for (int i = rob_ids.size() - 1; i > 0; i--) begin
			j          = $urandom % (i + 1);
			t          = rob_ids[i];
			rob_ids[i] = rob_ids[j];
			rob_ids[j] = t;
		end
		foreach (rob_ids[i]) begin
			complete($urandom % 2, rob_ids[i], {$urandom, $urandom});
		end
		wait_commits(10);
		finish_test(1, "out-of-order completion, in-order retire");

		// 2: source readiness and values through renaming
		apply_reset();
		dispatch_one(5'd5, 5'd7);               // reset state, ready zero
		dispatch_one(5'd9, 5'd5);               // r5 producer not granted yet
		complete(0, ROB_W'(0), 64'h0123_4567_89ab_cdef);
		dispatch_one(5'd10, 5'd5);              // cycle after the grant
		dispatch_one(5'd5, 5'd5);               // src == dest, older producer
		dispatch_one(ZERO_REG, 5'd5);           // new producer in flight
		dispatch_one(ZERO_REG, ZERO_REG);
		for (int i = 1; i < 6; i++) begin
			complete(1, ROB_W'(i), {$urandom, $urandom});
		end
		wait_commits(6);
		finish_test(2, "source forwarding through renaming");

		// 3: free list runs dry after eight renames
		apply_reset();
		for (int i = 1; i <= 8; i++) begin
			dispatch_one(arn_t'(i), ZERO_REG);
		end
		probe(5'd12, 3);
		for (int i = 0; i < 8; i++) begin
			dispatch_one(ZERO_REG, arn_t'(i));  // r31 needs no register
		end
		probe(ZERO_REG, 3);                     // buffer full
		finish_test(3, "free-list back-pressure");

		// 4: full buffer, then one retire frees a slot
		apply_reset();
		for (int i = 0; i < 16; i++) begin
			dispatch_one((i % 2) ? arn_t'(i / 2 + 1) : ZERO_REG, arn_t'(i));
		end
		probe(ZERO_REG, 3);
		complete(1, ROB_W'(0), {$urandom, $urandom});
		wait_commits(1);
		dispatch_one(ZERO_REG, ZERO_REG);
		finish_test(4, "reorder-buffer back-pressure");

		// 5: both ports at once, port 1 waits a cycle
		apply_reset();
		dispatch_one(5'd3, ZERO_REG);
		dispatch_one(5'd4, ZERO_REG);
		result_valid      = 2'b11;
		result_rob_idx[0] = ROB_W'(0);
		result_value[0]   = 64'haaaa_0000_1111_2222;
		result_rob_idx[1] = ROB_W'(1);
		result_value[1]   = 64'h5555_3333_4444_6666;
		drain_results();
		wait_commits(2);
		dispatch_one(ZERO_REG, 5'd3);
		dispatch_one(ZERO_REG, 5'd4);
		finish_test(5, "result arbitration");

		$display("5 tests run, %0d failed, %0d errors", failed_tests, all_errors());
		if (all_errors() == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: rename_core.f
hw/rename_pkg.sv
hw/rename_table.sv
hw/free_list.sv
hw/phys_regfile.sv
hw/cdb_arbiter.sv
hw/reorder_buffer.sv
hw/rename_core.sv
tb/rename_core_checker.sv
tb/rename_scoreboard.sv
tb/rename_core_tb.sv

// File: Bender.yml
package:
  name: rename_core

sources:
  - hw/rename_pkg.sv
  - hw/rename_table.sv
  - hw/free_list.sv
  - hw/phys_regfile.sv
  - hw/cdb_arbiter.sv
  - hw/reorder_buffer.sv
  - hw/rename_core.sv
  - target: test
    files:
      - tb/rename_core_checker.sv
      - tb/rename_scoreboard.sv
      - tb/rename_core_tb.sv
